/* logic/spi_cmd_decode.sv */
module spi_cmd_decode (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [spi_cmd_pkg::CMD_WIDTH-1:0] cmd_in,
  input  logic                              cmd_vld,
  input  logic                              frame_done,
  output logic                              cmd_rdy,
  output logic                              start,
  output logic [spi_cmd_pkg::CMD_WIDTH-1:0] tx_word,
  output logic [spi_cmd_pkg::BIT_CNT_W-1:0] tx_len,
  output logic                              do_read
);

  logic accept;

  assign accept = cmd_vld && cmd_rdy;

  // cmd_rdy doubles as the idle flag of the whole sequencer.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_rdy <= 1'b1;
    end
    else if (accept)
    begin
      cmd_rdy <= 1'b0;
    end
    else if (frame_done)
    begin
      cmd_rdy <= 1'b1;                // Ready again after the last cs rise.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start <= 1'b0;
    end
    else
    begin
      start <= accept;                // One cycle after acceptance.
    end
  end

  // Held for the whole frame, already MSB aligned.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      tx_word <= cmd_in;
    end
  end

  assign do_read = !tx_word[spi_cmd_pkg::WR_FLAG_BIT];

  always_comb
  begin
    if (do_read)
    begin
      tx_len = spi_cmd_pkg::TX_LEN_RD;  // Only flag and address go out.
    end
    else
    begin
      tx_len = spi_cmd_pkg::TX_LEN_WR;
    end
  end

endmodule

/* logic/spi_cmd_master.sv */
module spi_cmd_master (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [spi_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,
  output logic                               sclk,
  output logic                               cs,
  output logic                               mosi,
  input  logic                               miso,
  output logic                               read_vld,
  output logic [spi_cmd_pkg::READ_WIDTH-1:0] read_data
);

  logic                              start;
  logic [spi_cmd_pkg::CMD_WIDTH-1:0] tx_word;
  logic [spi_cmd_pkg::BIT_CNT_W-1:0] tx_len;
  logic                              do_read;
  logic                              frame_done;
  logic                              rx_sample;
  logic                              rx_last;

  spi_cmd_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .frame_done (frame_done),
    .cmd_rdy    (cmd_rdy),
    .start      (start),
    .tx_word    (tx_word),
    .tx_len     (tx_len),
    .do_read    (do_read)
  );

  spi_engine u_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .tx_word    (tx_word),
    .tx_len     (tx_len),
    .do_read    (do_read),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .rx_sample  (rx_sample),
    .rx_last    (rx_last),
    .frame_done (frame_done)
  );

  // Samples miso at the engine's rising sclk points.
  spi_read_capture u_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .miso       (miso),
    .rx_sample  (rx_sample),
    .rx_last    (rx_last),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

endmodule

/* logic/spi_cmd_pkg.sv */
package spi_cmd_pkg;

  localparam int CMD_WIDTH   = 12;
  localparam int READ_WIDTH  = 8;
  localparam int ADDR_BITS   = 4;   // Flag plus 3-bit address.
  localparam int SCLK_HALF   = 4;
  localparam int READ_GAP    = 100;
  localparam int BIT_CNT_W   = 4;
  localparam int WR_FLAG_BIT = CMD_WIDTH - 1;

  // Divider runs over one full sclk period.
  localparam int DIV_CNT_W = $clog2(2 * SCLK_HALF);
  localparam int GAP_CNT_W = $clog2(READ_GAP);

  localparam logic [BIT_CNT_W-1:0] TX_LEN_WR   = BIT_CNT_W'(CMD_WIDTH);
  localparam logic [BIT_CNT_W-1:0] TX_LEN_RD   = BIT_CNT_W'(ADDR_BITS);
  localparam logic [BIT_CNT_W-1:0] RX_LAST_BIT = BIT_CNT_W'(READ_WIDTH - 1);

  localparam logic [DIV_CNT_W-1:0] DIV_RISE = DIV_CNT_W'(SCLK_HALF - 1);     // Last low cycle.
  localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(2 * SCLK_HALF - 1); // Last high cycle.

  localparam logic [GAP_CNT_W-1:0] GAP_LAST = GAP_CNT_W'(READ_GAP - 1);

  typedef enum logic [2:0] {
    IDLE,
    TX,
    GAP,
    RX,
    DONE
  } spi_phase_t;

endpackage

/* logic/spi_engine.sv */
module spi_engine (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start,
  input  logic [spi_cmd_pkg::CMD_WIDTH-1:0] tx_word,
  input  logic [spi_cmd_pkg::BIT_CNT_W-1:0] tx_len,
  input  logic                              do_read,
  output logic                              sclk,
  output logic                              cs,
  output logic                              mosi,
  output logic                              rx_sample,
  output logic                              rx_last,
  output logic                              frame_done
);

  spi_cmd_pkg::spi_phase_t state;
  spi_cmd_pkg::spi_phase_t state_nxt;

  logic [spi_cmd_pkg::DIV_CNT_W-1:0] div_cnt;
  logic [spi_cmd_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [spi_cmd_pkg::GAP_CNT_W-1:0] gap_cnt;
  logic [spi_cmd_pkg::CMD_WIDTH-1:0] tx_shift;

  logic active;
  logic sclk_rise;
  logic bit_end;
  logic tx_done;
  logic gap_done;
  logic rx_done;

  assign active    = (state == spi_cmd_pkg::TX) || (state == spi_cmd_pkg::RX);
  assign sclk_rise = active && (div_cnt == spi_cmd_pkg::DIV_RISE);
  assign bit_end   = active && (div_cnt == spi_cmd_pkg::DIV_LAST);

  assign tx_done  = (state == spi_cmd_pkg::TX) && bit_end && (bit_cnt == tx_len - 1'b1);
  assign rx_done  = (state == spi_cmd_pkg::RX) && bit_end &&
                    (bit_cnt == spi_cmd_pkg::RX_LAST_BIT);
  assign gap_done = (state == spi_cmd_pkg::GAP) && (gap_cnt == spi_cmd_pkg::GAP_LAST);

  always_comb
  begin
    state_nxt = state;
    case (state)
      spi_cmd_pkg::IDLE:
      begin
        if (start)
        begin
          state_nxt = spi_cmd_pkg::TX;
        end
      end
      spi_cmd_pkg::TX:
      begin
        if (tx_done && do_read)
        begin
          state_nxt = spi_cmd_pkg::GAP;
        end
        else if (tx_done)
        begin
          state_nxt = spi_cmd_pkg::DONE;
        end
      end
      spi_cmd_pkg::GAP:
      begin
        if (gap_done)
        begin
          state_nxt = spi_cmd_pkg::RX;
        end
      end
      spi_cmd_pkg::RX:
      begin
        if (rx_done)
        begin
          state_nxt = spi_cmd_pkg::DONE;
        end
      end
      spi_cmd_pkg::DONE:
      begin
        state_nxt = spi_cmd_pkg::IDLE;  // Single cycle for frame_done.
      end
      default:
      begin
        state_nxt = spi_cmd_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= spi_cmd_pkg::IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  // Divider and bit counter only run while cs is low.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!active)
    begin
      div_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (bit_end)
    begin
      div_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gap_cnt <= '0;
    end
    else if (state == spi_cmd_pkg::GAP)
    begin
      gap_cnt <= gap_cnt + 1'b1;
    end
    else
    begin
      gap_cnt <= '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk <= 1'b0;
    end
    else if (sclk_rise)
    begin
      sclk <= 1'b1;
    end
    else if (bit_end || !active)
    begin
      sclk <= 1'b0;                   // Falling edge closes the bit.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs <= 1'b1;
    end
    else
    begin
      cs <= !((state_nxt == spi_cmd_pkg::TX) || (state_nxt == spi_cmd_pkg::RX));
    end
  end

  // Cleared after the last bit so mosi stays low through gap and receive.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_shift <= '0;
    end
    else if ((state == spi_cmd_pkg::IDLE) && start)
    begin
      tx_shift <= tx_word;
    end
    else if (tx_done)
    begin
      tx_shift <= '0;
    end
    else if ((state == spi_cmd_pkg::TX) && bit_end)
    begin
      tx_shift <= tx_shift << 1;      // Next bit with the falling edge.
    end
  end

  assign mosi = tx_shift[spi_cmd_pkg::CMD_WIDTH-1];

  assign rx_sample  = (state == spi_cmd_pkg::RX) && sclk_rise;
  assign rx_last    = rx_sample && (bit_cnt == spi_cmd_pkg::RX_LAST_BIT);
  assign frame_done = (state == spi_cmd_pkg::DONE);

endmodule

/* logic/spi_read_capture.sv */
module spi_read_capture (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               miso,
  input  logic                               rx_sample,
  input  logic                               rx_last,
  output logic                               read_vld,
  output logic [spi_cmd_pkg::READ_WIDTH-1:0] read_data
);

  // The final bit comes straight from miso, so one bit less is stored.
  logic [spi_cmd_pkg::READ_WIDTH-2:0] rx_shift;

  always_ff @(posedge clk)
  begin
    if (rx_sample)
    begin
      rx_shift <= {rx_shift[spi_cmd_pkg::READ_WIDTH-3:0], miso};  // MSB first.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_data <= '0;
    end
    else if (rx_last)
    begin
      read_data <= {rx_shift, miso};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= rx_last;            // Lines up with the new read_data.
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SPI command master testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_spi_cmd_master \
  -f spi_cmd_master.f \
  -o tb_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; cat build.log; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qx "TEST OK" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* sim/spi_slave_model.sv */
module spi_slave_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  regs [0:7];
  logic [11:0] shift = '0;
  int          count = 0;
  logic [11:0] last_frame = '0;   // Read by the testbench.
  int          last_count = 0;
  logic [2:0]  rd_addr = '0;
  logic [7:0]  tx_byte = '0;

  initial
  begin
    for (int i = 0; i < 8; i++)
    begin
      regs[i] = 8'h00;
    end
    miso = 1'b0;
  end

  always @(negedge cs)
  begin
    count   = 0;
    shift   = '0;
    tx_byte = regs[rd_addr];
    miso    = tx_byte[7];         // First bit ready before any edge.
  end

  always @(posedge sclk)
  begin
    if (cs == 1'b0)
    begin
      shift = {shift[10:0], mosi};
      count = count + 1;
    end
  end

  always @(negedge sclk)
  begin
    if (cs == 1'b0)
    begin
      tx_byte = tx_byte << 1;
      miso    = tx_byte[7];
    end
  end

  always @(posedge cs)
  begin
    last_frame = shift;
    last_count = count;
    if ((count == 12) && shift[11])
    begin
      regs[shift[10:8]] = shift[7:0];
    end
    else if ((count == 4) && !shift[3])
    begin
      rd_addr = shift[2:0];       // Address for the next data frame.
    end
  end

endmodule

/* sim/tb_spi_cmd_master.sv */
module tb_spi_cmd_master;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CMDS = 9;
  localparam int TIMEOUT  = 2000;

  logic        clk;
  logic        rst_n;
  logic [11:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        miso;
  logic        read_vld;
  logic [7:0]  read_data;

  logic [11:0] tbl_cmd [NUM_CMDS];
  logic [7:0]  exp_regs [0:7];

  int          low_run = 0;
  int          high_run = 0;
  int          lows[$];
  int          gaps[$];
  int          edges[$];
  logic [11:0] frames[$];
  bit          mosi_seen = 0;
  bit          mosi_flags[$];
  int          vld_count = 0;
  logic [7:0]  last_read = '0;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_passed = 0;

  spi_cmd_master DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .sclk (sclk),
    .cs   (cs),
    .mosi (mosi),
    .miso (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // One record per cs-low run.
  always @(negedge clk)
  begin
    if (cs === 1'b0)
    begin
      if (high_run != 0)
      begin
        gaps.push_back(high_run);
        high_run = 0;
      end
      low_run = low_run + 1;
      if (mosi)
      begin
        mosi_seen = 1;
      end
    end
    else
    begin
      if (low_run != 0)
      begin
        lows.push_back(low_run);
        edges.push_back(u_slave.last_count);
        frames.push_back(u_slave.last_frame);
        mosi_flags.push_back(mosi_seen);
        low_run   = 0;
        mosi_seen = 0;
      end
      high_run = high_run + 1;
    end
    if (read_vld)
    begin
      vld_count = vld_count + 1;
      last_read = read_data;
    end
  end

  function automatic logic [11:0] make_cmd(input bit wr, input logic [2:0] addr,
                                           input logic [7:0] data);
    logic [11:0] c;
    c = {1'b0, addr, data};
    c[spi_cmd_pkg::WR_FLAG_BIT] = wr;
    return c;
  endfunction

  task automatic check_val(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("CHECK FAILED at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at %0d ns while waiting for %s", $time, what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic clear_monitor();
    lows.delete();
    gaps.delete();
    edges.delete();
    frames.delete();
    mosi_flags.delete();
    vld_count = 0;
  endtask

  task automatic send_cmd(input logic [11:0] c);
    int n;
    bit acc;
    n   = 0;
    acc = 0;
    @(negedge clk);
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!acc)
    begin
      @(posedge clk);
      if (cmd_rdy)
      begin
        acc = 1;
      end
      else
      begin
        n = n + 1;
        if (n > TIMEOUT)
        begin
          timeout_fail("command acceptance");
        end
      end
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk);
    while (!cmd_rdy)
    begin
      @(posedge clk);
      n = n + 1;
      if (n > TIMEOUT)
      begin
        timeout_fail("cmd_rdy after a command");
      end
    end
    @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run = tests_run + 1;
    if (errors == errs_before)
    begin
      tests_passed = tests_passed + 1;
      $display("test %0d %s: passed", tests_run, name);
    end
    else
    begin
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  task automatic check_reset_outputs();
    check_val("cs", cs, 1);
    check_val("sclk", sclk, 0);
    check_val("mosi", mosi, 0);
    check_val("read_vld", read_vld, 0);
    check_val("read_data", read_data, 0);
    check_val("cmd_rdy", cmd_rdy, 1);
  endtask

  task automatic run_table_entry(input logic [11:0] c);
    int eb;
    logic [2:0] addr;
    eb   = errors;
    addr = c[10:8];
    clear_monitor();
    send_cmd(c);
    wait_idle();
    if (c[spi_cmd_pkg::WR_FLAG_BIT])
    begin
      exp_regs[addr] = c[7:0];
      check_val("frame count", lows.size(), 1);
      if (lows.size() == 1)
      begin
        check_val("cs low cycles", lows[0], 96);
        check_val("sclk rising edges", edges[0], 12);
        check_val("slave frame", frames[0], c);
      end
      check_val("slave register", u_slave.regs[addr], exp_regs[addr]);
      check_val("read_vld pulses", vld_count, 0);
      finish_test($sformatf("write addr %0d", addr), eb);
    end
    else
    begin
      check_val("frame count", lows.size(), 2);
      check_val("cs high run count", gaps.size(), 2);
      if ((lows.size() == 2) && (gaps.size() == 2))
      begin
        check_val("address cs low cycles", lows[0], 32);
        check_val("address sclk edges", edges[0], 4);
        check_val("address frame", frames[0][3:0], c[11:8]);
        check_val("cs gap cycles", gaps[1], 100);
        check_val("data cs low cycles", lows[1], 64);
        check_val("data sclk edges", edges[1], 8);
        check_val("mosi during data frame", mosi_flags[1], 0);
      end
      check_val("read_vld pulses", vld_count, 1);
      check_val("read_data", last_read, exp_regs[addr]);
      finish_test($sformatf("read addr %0d", addr), eb);
    end
  endtask

  task automatic holdoff_test(input logic [11:0] a, input logic [11:0] b);
    int eb;
    int n;
    int cs_hi_at;
    int rdy_at;
    bit seen_low;
    eb       = errors;
    n        = 0;
    cs_hi_at = -1;
    rdy_at   = -1;
    seen_low = 0;
    clear_monitor();
    send_cmd(a);
    cmd_in  = b;                  // Second command waits with vld high.
    cmd_vld = 1'b1;
    while (rdy_at < 0)
    begin
      @(posedge clk);
      n = n + 1;
      if (cs === 1'b0)
      begin
        seen_low = 1;
      end
      else if (seen_low && (cs_hi_at < 0))
      begin
        cs_hi_at = n;
      end
      if (cmd_rdy)
      begin
        rdy_at = n;
      end
      if (n > TIMEOUT)
      begin
        timeout_fail("cmd_rdy during hold-off");
      end
    end
    @(negedge clk);
    cmd_vld = 1'b0;
    wait_idle();
    exp_regs[a[10:8]] = a[7:0];
    exp_regs[b[10:8]] = b[7:0];
    check_val("cmd_rdy delay after cs rise", rdy_at - cs_hi_at, 1);
    check_val("frame count", lows.size(), 2);
    if (lows.size() == 2)
    begin
      check_val("first frame", frames[0], a);
      check_val("second frame", frames[1], b);
    end
    check_val("second register", u_slave.regs[b[10:8]], exp_regs[b[10:8]]);
    check_val("read_vld pulses", vld_count, 0);
    finish_test("hold-off", eb);
  endtask

  initial
  begin
    int eb;
    void'($urandom(97626));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      exp_regs[i] = 8'h00;
    end

    // Reads carry nonzero filler in the data field.
    tbl_cmd[0] = make_cmd(1'b1, 3'd1, 8'h5a);
    tbl_cmd[1] = make_cmd(1'b0, 3'd1, 8'hff);
    tbl_cmd[2] = make_cmd(1'b1, 3'd3, 8'($urandom));
    tbl_cmd[3] = make_cmd(1'b1, 3'd6, 8'($urandom));
    tbl_cmd[4] = make_cmd(1'b0, 3'd3, 8'ha5);
    tbl_cmd[5] = make_cmd(1'b0, 3'd6, 8'h3c);
    tbl_cmd[6] = make_cmd(1'b0, 3'd0, 8'hff);
    tbl_cmd[7] = make_cmd(1'b1, 3'd6, 8'($urandom));
    tbl_cmd[8] = make_cmd(1'b0, 3'd6, 8'h81);

    eb = errors;
    repeat (16)
    begin
      @(negedge clk);
      check_reset_outputs();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_outputs();
    finish_test("reset state", eb);

    for (int i = 0; i < NUM_CMDS; i++)
    begin
      run_table_entry(tbl_cmd[i]);
    end

    holdoff_test(make_cmd(1'b1, 3'd2, 8'($urandom)), make_cmd(1'b1, 3'd5, 8'($urandom)));

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if ((errors == 0) && (tests_passed == tests_run))
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* spi_cmd_master.f */
logic/spi_cmd_pkg.sv
logic/spi_cmd_decode.sv
logic/spi_engine.sv
logic/spi_read_capture.sv
logic/spi_cmd_master.sv
sim/spi_slave_model.sv
sim/tb_spi_cmd_master.sv
